// ==== design/cache_pkg.sv ====
/* shared widths, bus structs and fill states for the read-only cache
   byte addressed 16-bit words, bit 0 of every address is ignored */
package cache_pkg;

    // processor and memory both use 16-bit addresses and 16-bit words
    localparam int addr_w = 16;
    localparam int data_w = 16;

    // a line holds eight words, so three bits pick the word inside it
    localparam int words_per_line = 8;
    localparam int offset_w = 3;

    // one byte-select bit sits below the word offset
    localparam int byte_w = 1;

    // main memory does not store anything, each word is derived from its address
    localparam logic [data_w-1:0] mem_xor_pattern = 16'h5A5A;

    // processor read request, held steady by the processor while stall is high
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
    } cpu_req_t;

    // read data back to the processor, valid for a single cycle
    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] data;
    } cpu_rsp_t;

    // word read towards main memory, one may be issued every cycle
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
    } mem_req_t;

    // word returning from main memory, in request order
    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] data;
    } mem_rsp_t;

    // the fill FSM is idle, streaming a line in, or writing the tag
    typedef enum logic [1:0] {
        fill_idle      = 2'd0,
        fill_busy      = 2'd1,
        fill_tag_write = 2'd2
    } fill_state_e;

    // the memory rule, the byte bit is dropped before the xor
    function automatic logic [data_w-1:0] mem_rule_word(input logic [addr_w-1:0] addr);
        return {addr[addr_w-1:byte_w], {byte_w{1'b0}}} ^ mem_xor_pattern;
    endfunction

endpackage

// ==== design/cache_lookup.sv ====
/* tag and valid store for a direct-mapped cache of 2**INDEX_W lines
   the request must stay unchanged from the miss until tag_we, the tag is taken from it */
`timescale 1ns/1ps

module cache_lookup #(
    parameter int INDEX_W = 3
) (
    input  logic               clk,
    input  logic               arst_n,
    input  cache_pkg::cpu_req_t req,
    input  logic               tag_we,       // last word of the line is in, store tag and valid
    output logic               hit,
    output logic               miss_detected
);

    import cache_pkg::*;

    localparam int lines = 2 ** INDEX_W;
    // tag is whatever sits above index, word offset and byte bit
    localparam int tag_w = addr_w - INDEX_W - offset_w - byte_w;

    logic [INDEX_W-1:0] req_index;
    logic [tag_w-1:0]   req_tag;

    logic [tag_w-1:0]   tag_mem [lines];     // stored tags, meaningless until the valid bit is set
    logic [lines-1:0]   line_vld;            // one valid bit per line

    logic               tag_match;

    // address split: | tag | index | word offset | byte |
    assign req_index = req.addr[offset_w+byte_w +: INDEX_W];
    assign req_tag   = req.addr[addr_w-1 -: tag_w];

    // the valid bits have to come up cleared so that nothing hits after reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            line_vld <= '0;
        end else if (tag_we) begin
            line_vld[req_index] <= 1'b1;     // the line is complete from now on
        end
    end

    // tag storage itself is plain memory
    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[req_index] <= req_tag;
        end
    end

    assign tag_match = (tag_mem[req_index] == req_tag);

    // a hit needs a live request, a filled line and the same tag
    assign hit = req.valid & line_vld[req_index] & tag_match;

    // stays high through the whole fill because the request is held,
    // the fill FSM only looks at it while idle
    assign miss_detected = req.valid & ~hit;

endmodule

// ==== design/cache_fill_fsm.sv ====
/* line fill on a miss: eight word reads go out back to back, data is written as it returns
   assumes memory takes a request every cycle and answers in order */
`timescale 1ns/1ps

module cache_fill_fsm #(
    parameter int INDEX_W = 3
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [15:0]         miss_addr,      // address of the held, missing request
    input  logic                miss_detected,
    input  cache_pkg::mem_rsp_t mem_rsp,
    output cache_pkg::mem_req_t mem_req,
    output logic                data_we,        // write the returning word into the data array
    output logic [2:0]          fill_offset,    // word of the line that data_we writes
    output logic                tag_we,         // one pulse once the whole line is in
    output logic                busy            // a fill is in progress
);

    import cache_pkg::*;

    localparam int tag_w = addr_w - INDEX_W - offset_w - byte_w;
    localparam logic [offset_w-1:0] last_word = offset_w'(words_per_line - 1);

    fill_state_e state_q;
    fill_state_e state_d;

    logic [offset_w-1:0] req_cnt;   // word being requested, steps every cycle a request goes out
    logic [offset_w-1:0] rcv_cnt;   // word being received, steps only on valid return data
    logic                req_done;  // all eight requests are out, wait for the data

    logic [tag_w-1:0]    miss_tag;
    logic [INDEX_W-1:0]  miss_index;

    assign miss_tag   = miss_addr[addr_w-1 -: tag_w];
    assign miss_index = miss_addr[offset_w+byte_w +: INDEX_W];

    always_comb begin
        state_d = state_q;
        case (state_q)
            fill_idle: begin
                if (miss_detected) begin
                    state_d = fill_busy;   // busy rises on the edge after the miss is seen
                end
            end
            fill_busy: begin
                // leave as soon as the eighth word is being written
                if (data_we && rcv_cnt == last_word) begin
                    state_d = fill_tag_write;
                end
            end
            fill_tag_write: state_d = fill_idle;   // single cycle for the tag write
            default:        state_d = fill_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= fill_idle;
            req_cnt  <= '0;
            rcv_cnt  <= '0;
            req_done <= 1'b0;
        end else begin
            state_q <= state_d;

            // both counters wrap back to zero after the eighth step, ready for the next miss
            if (mem_req.valid) begin
                req_cnt <= req_cnt + 1'b1;
            end
            if (data_we) begin
                rcv_cnt <= rcv_cnt + 1'b1;
            end

            if (state_q == fill_idle) begin
                req_done <= 1'b0;
            end else if (mem_req.valid && req_cnt == last_word) begin
                req_done <= 1'b1;   // no more requests for this line
            end
        end
    end

    assign busy = (state_q != fill_idle);

    // one read per cycle from the first busy cycle until eight have gone out
    assign mem_req.valid = (state_q == fill_busy) & ~req_done;
    // line base plus the request count, byte bit always zero
    assign mem_req.addr  = {miss_tag, miss_index, req_cnt, {byte_w{1'b0}}};

    // returning data only counts while the line is being filled
    assign data_we     = mem_rsp.valid & (state_q == fill_busy);
    assign fill_offset = rcv_cnt;

    assign tag_we = (state_q == fill_tag_write);

endmodule

// ==== design/cache_data_array.sv ====
/* word storage, 2**INDEX_W lines of eight words, one write port and one registered read
   write and read must not be requested in the same cycle */
`timescale 1ns/1ps

module cache_data_array #(
    parameter int INDEX_W = 3
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [INDEX_W-1:0]  index,
    input  logic [2:0]          word_sel,   // fill offset while writing, request word while reading
    input  logic                we,
    input  logic [15:0]         wdata,
    input  logic                rd_en,      // an accepted hit
    output cache_pkg::cpu_rsp_t rsp
);

    import cache_pkg::*;

    localparam int depth = (2 ** INDEX_W) * words_per_line;

    logic [data_w-1:0] word_mem [depth];

    logic [INDEX_W+offset_w-1:0] word_addr;

    logic [data_w-1:0] rdata_q;     // last word read out
    logic              rsp_vld_q;   // strobe for the word above

    // line number on top, word within the line below
    assign word_addr = {index, word_sel};

    always_ff @(posedge clk) begin
        if (we) begin
            word_mem[word_addr] <= wdata;
        end
        if (rd_en) begin
            rdata_q <= word_mem[word_addr];   // holds its value between hits
        end
    end

    // the response strobe is one cycle long, one cycle after the accept
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_vld_q <= 1'b0;
        end else begin
            rsp_vld_q <= rd_en;
        end
    end

    assign rsp.valid = rsp_vld_q;
    assign rsp.data  = rdata_q;

endmodule

// ==== design/main_memory.sv ====
/* behavioral main memory, every request is answered MEM_LATENCY cycles later in order
   no storage, the word comes from the address rule, MEM_LATENCY must be at least 1 */
`timescale 1ns/1ps

module main_memory #(
    parameter int MEM_LATENCY = 4
) (
    input  logic                clk,
    input  logic                arst_n,
    input  cache_pkg::mem_req_t req,
    output cache_pkg::mem_rsp_t rsp
);

    import cache_pkg::*;

    logic [MEM_LATENCY-1:0] vld_pipe;               // one valid flag per stage
    logic [data_w-1:0]      dat_pipe [MEM_LATENCY]; // word travelling alongside it

    logic [data_w-1:0]      req_word;

    // the word is known when the request arrives, the pipeline only delays it
    assign req_word = mem_rule_word(req.addr);

    // valid flags must start empty, otherwise the cache would take junk after reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= req.valid;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    // data stages follow the valid flags
    always_ff @(posedge clk) begin
        dat_pipe[0] <= req_word;
        for (int i = 1; i < MEM_LATENCY; i++) begin
            dat_pipe[i] <= dat_pipe[i-1];
        end
    end

    // a new request can enter every cycle, so nothing ever waits
    assign rsp.valid = vld_pipe[MEM_LATENCY-1];
    assign rsp.data  = dat_pipe[MEM_LATENCY-1];

endmodule

// ==== design/cache_top.sv ====
/* read-only direct-mapped cache with its behavioral memory, processor side only
   the processor must hold cpu_req steady while stall is high */
`timescale 1ns/1ps

module cache_top #(
    parameter int INDEX_W     = 3,   // 2**INDEX_W lines
    parameter int MEM_LATENCY = 4    // memory read latency in cycles
) (
    input  logic                clk,
    input  logic                arst_n,
    input  cache_pkg::cpu_req_t cpu_req,
    output cache_pkg::cpu_rsp_t cpu_rsp,
    output logic                stall
);

    import cache_pkg::*;

    logic                hit;
    logic                miss_detected;
    logic                busy;
    logic                data_we;
    logic [offset_w-1:0] fill_offset;
    logic                tag_we;
    logic                rd_en;

    logic [INDEX_W-1:0]  req_index;
    logic [offset_w-1:0] req_word;
    logic [offset_w-1:0] word_sel;

    mem_req_t            mem_req;
    mem_rsp_t            mem_rsp;

    assign req_index = cpu_req.addr[offset_w+byte_w +: INDEX_W];
    assign req_word  = cpu_req.addr[byte_w +: offset_w];

    // a miss stalls in the same cycle so it is never accepted
    assign stall = busy | miss_detected;

    // a hit outside a fill is the only thing that reads the array
    assign rd_en = cpu_req.valid & hit & ~busy;

    // fills write at the receive count, reads use the request word
    assign word_sel = data_we ? fill_offset : req_word;

    cache_lookup #(
        .INDEX_W (INDEX_W)
    ) u_lookup (
        .clk           (clk),
        .arst_n        (arst_n),
        .req           (cpu_req),
        .tag_we        (tag_we),
        .hit           (hit),
        .miss_detected (miss_detected)
    );

    cache_fill_fsm #(
        .INDEX_W (INDEX_W)
    ) u_fill (
        .clk           (clk),
        .arst_n        (arst_n),
        .miss_addr     (cpu_req.addr),   // held by the processor for the whole fill
        .miss_detected (miss_detected),
        .mem_rsp       (mem_rsp),
        .mem_req       (mem_req),
        .data_we       (data_we),
        .fill_offset   (fill_offset),
        .tag_we        (tag_we),
        .busy          (busy)
    );

    cache_data_array #(
        .INDEX_W (INDEX_W)
    ) u_data (
        .clk      (clk),
        .arst_n   (arst_n),
        .index    (req_index),
        .word_sel (word_sel),
        .we       (data_we),
        .wdata    (mem_rsp.data),
        .rd_en    (rd_en),
        .rsp      (cpu_rsp)
    );

    main_memory #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_mem (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (mem_req),
        .rsp    (mem_rsp)
    );

endmodule

// ==== sim/cache_chk.sv ====
/* concurrent checks on the fill FSM handshake, bound into every cache_fill_fsm
   assumes a line of eight words and a memory that never back-pressures */
`timescale 1ns/1ps

module cache_chk (
    input logic                clk,
    input logic                arst_n,
    input cache_pkg::mem_req_t mem_req,
    input cache_pkg::mem_rsp_t mem_rsp,
    input logic                busy,
    input logic                data_we,
    input logic                tag_we
);

    logic [3:0] dwe_cnt;      // words written since the last tag write
    logic [3:0] req_issued;   // memory reads sent out since the last tag write

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dwe_cnt    <= '0;
            req_issued <= '0;
        end else if (tag_we) begin
            dwe_cnt    <= '0;   // next fill counts from zero again
            req_issued <= '0;
        end else begin
            if (data_we) begin
                dwe_cnt <= dwe_cnt + 1'b1;
            end
            if (mem_req.valid) begin
                req_issued <= req_issued + 1'b1;
            end
        end
    end

    // memory reads only go out while a fill is running, and only eight per line
    req_inside_busy: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req.valid |-> busy && (req_issued < 4'd8))
        else $error("memory request outside a fill or beyond the eighth word of the line");

    // the tag is written right after the eighth word, never earlier
    tag_after_last_word: assert property (@(posedge clk) disable iff (!arst_n)
        tag_we |-> (dwe_cnt == 4'd8) && $past(data_we))
        else $error("tag write without eight words written just before it");

    // every returning word lands in the array, so none can arrive during the tag write
    rsp_written: assert property (@(posedge clk) disable iff (!arst_n)
        mem_rsp.valid |-> data_we)
        else $error("memory word returned while no data write was possible");

endmodule

bind cache_fill_fsm cache_chk u_chk (
    .clk     (clk),
    .arst_n  (arst_n),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .busy    (busy),
    .data_we (data_we),
    .tag_we  (tag_we)
);

// ==== sim/cache_tb.sv ====
/* drives cache_top from a table of reads and samples every output on the falling clock edge
   expected data comes from the memory rule, expected hit or miss from a tag model kept here */
`timescale 1ns/1ps

module cache_tb;

    import cache_pkg::*;

    localparam int index_w     = 3;
    localparam int mem_latency = 4;
    localparam int lines       = 2 ** index_w;
    localparam int tag_w       = 16 - index_w - 4;   // above index, word offset and byte bit
    localparam int n_fixed     = 7;
    localparam int n_entries   = 24;
    // a miss costs the eight requests, the latency and a few cycles of handshake
    localparam int cycle_limit = n_entries * (8 + mem_latency + 4) + 50;

    // cold miss, two hits in the same line, then two tags fighting over index 0
    localparam logic [15:0] fixed_addr [n_fixed] = '{
        16'h0100, 16'h010A, 16'h010E, 16'h0900, 16'h0104, 16'h0906, 16'h0907
    };

    typedef struct packed {
        logic [15:0] addr;
        logic        exp_hit;   // predicted by the tag model when the table is built
    } stim_t;

    logic     clk;
    logic     arst_n;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    logic     stall;

    stim_t            stim      [n_entries];
    logic [tag_w-1:0] model_tag [lines];
    logic [lines-1:0] model_vld;

    int pass_count;
    int fail_count;
    int cycle_cnt = 0;

    cache_top #(
        .INDEX_W     (index_w),
        .MEM_LATENCY (mem_latency)
    ) DUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .stall   (stall)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;   // 20 ns period

    // the run cannot outlive the worst case of every entry missing
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: no end of the test run after %0d clock cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // memory holds the even byte address of each word, scrambled with 5A5A
    function automatic logic [15:0] expected_word(input logic [15:0] addr);
        logic [15:0] even_addr;
        even_addr = addr & 16'hFFFE;
        return even_addr ^ 16'h5A5A;
    endfunction

    task automatic build_table();
        logic [31:0]        rnd;
        logic [15:0]        addr;
        logic [index_w-1:0] idx;
        logic [tag_w-1:0]   tag;
        rnd       = 32'd32;
        model_vld = '0;
        for (int i = 0; i < n_entries; i++) begin
            if (i < n_fixed) begin
                addr = fixed_addr[i];
            end else begin
                rnd  = xorshift32(rnd);
                addr = rnd[15:0] & 16'h01FF;   // only four tags, so lines conflict often
            end
            idx = addr[4 +: index_w];
            tag = addr[15 -: tag_w];
            stim[i].addr    = addr;
            stim[i].exp_hit = model_vld[idx] && (model_tag[idx] == tag);
            model_vld[idx]  = 1'b1;   // after the access the line holds this tag either way
            model_tag[idx]  = tag;
        end
    endtask

    task automatic report_test(input string label, input logic ok);
        if (ok) begin
            pass_count++;
            $display("%s: ok", label);
        end else begin
            fail_count++;
            $display("%s: error", label);
        end
    endtask

    // one read, held until accepted, returns the data and whether stall was ever seen
    task automatic run_access(input logic [15:0] addr, output logic seen_stall,
                              output logic [15:0] rdata);
        logic accepted;
        logic got_rsp;
        accepted   = 1'b0;
        got_rsp    = 1'b0;
        seen_stall = 1'b0;
        rdata      = '0;
        @(posedge clk);
        cpu_req <= {1'b1, addr};
        while (!got_rsp) begin
            @(negedge clk);
            if (cpu_rsp.valid) begin
                got_rsp = 1'b1;
                rdata   = cpu_rsp.data;
            end else if (stall) begin
                seen_stall = 1'b1;
            end else if (!accepted) begin
                accepted = 1'b1;   // stall is low, so the coming edge takes the request
                @(posedge clk);
                cpu_req <= '0;
            end
        end
    endtask

    task automatic check_idle_after_reset();
        logic ok;
        ok = 1'b1;
        repeat (3) begin
            @(negedge clk);
            assert (!stall && !cpu_rsp.valid) else begin
                $display("[FAIL] stall %h cpu_rsp.valid %h with no request, exp 0 and 0",
                         stall, cpu_rsp.valid);
                ok = 1'b0;
            end
        end
        report_test("idle after reset", ok);
    endtask

    task automatic check_entry(input int n);
        logic        seen_stall;
        logic [15:0] rdata;
        logic [15:0] exp_data;
        logic        ok;
        string       label;
        exp_data = expected_word(stim[n].addr);
        ok       = 1'b1;
        run_access(stim[n].addr, seen_stall, rdata);
        assert (rdata == exp_data) else begin
            $display("[FAIL] entry %0d addr %h cpu_rsp.data got %h exp %h",
                     n, stim[n].addr, rdata, exp_data);
            ok = 1'b0;
        end
        // a miss must show stall, a hit must never
        assert (seen_stall == !stim[n].exp_hit) else begin
            $display("[FAIL] entry %0d addr %h stall got %h exp %h",
                     n, stim[n].addr, seen_stall, !stim[n].exp_hit);
            ok = 1'b0;
        end
        label = $sformatf("entry %0d addr %h expected %s data %h", n, stim[n].addr,
                          stim[n].exp_hit ? "hit" : "miss", rdata);
        report_test(label, ok);
    endtask

    initial begin
        cpu_req    = '0;
        arst_n     = 1'b0;
        pass_count = 0;
        fail_count = 0;
        build_table();
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        check_idle_after_reset();
        for (int i = 0; i < n_entries; i++) begin
            check_entry(i);
        end
        $display("tests done: %0d ok, %0d with errors", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
design/cache_pkg.sv
design/cache_lookup.sv
design/cache_fill_fsm.sv
design/cache_data_array.sv
design/main_memory.sv
design/cache_top.sv
sim/cache_chk.sv
sim/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cache_tb -f sources.f -o cache_sim \
    && ./obj_dir/cache_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TEST PASSED$" sim.log && echo "simulation ok" \
    || { echo "simulation did not pass"; exit 1; }
